/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int DATA_W    = 32;            // Data word and byte address width
    localparam int REG_AW    = 5;             // Register file index width
    localparam int RAM_AW    = 8;             // Word index into the data RAM
    localparam int RAM_WORDS = 1 << RAM_AW;   // Data RAM depth in words

    // Control bits that ride from execute to write-back untouched
    typedef struct packed {
        logic              mem_to_reg;        // Write the loaded word
        logic              reg_write;         // Register file write enable
        logic [REG_AW-1:0] reg_dest;          // Destination register
        logic              reg_data_src;      // Write the link address instead
        logic              pc_src;            // Take the branch target
    } wb_ctrl_t;

    // Execute to memory bundle, one instruction per clock
    typedef struct packed {
        logic [DATA_W-1:0] alu_result;        // Also the byte address
        logic [DATA_W-1:0] store_data;        // Word to store
        logic [DATA_W-1:0] link_pc;           // Return address for link writes
        logic              mem_read;          // Load strobe
        logic              mem_write;         // Store strobe
        wb_ctrl_t          ctrl;
    } ex_mem_t;

    // Memory to write-back bundle; the RAM word arrives beside it
    typedef struct packed {
        logic [DATA_W-1:0] alu_result;
        logic [DATA_W-1:0] link_pc;
        wb_ctrl_t          ctrl;
    } mem_wb_t;

    // Result leaving the pipeline
    typedef struct packed {
        logic              reg_write;
        logic [REG_AW-1:0] reg_dest;
        logic [DATA_W-1:0] reg_data;          // Value written to the register file
        logic              pc_src;
        logic [DATA_W-1:0] pc_target;         // Branch target, the ALU result
    } wb_out_t;

endpackage

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

// Memory access stage. Holds the execute bundle for one cycle and
// presents it to the data RAM; the RAM samples it on the next edge.
module mem_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_pkg::ex_mem_t           ex_in,
    output logic [cpu_pkg::RAM_AW-1:0] ram_addr,
    output logic [cpu_pkg::DATA_W-1:0] ram_wdata,
    output logic                       ram_we,
    output cpu_pkg::mem_wb_t           mem_wb,
    output logic                       mem_done
);

    import cpu_pkg::*;

    ex_mem_t ex_q;       // Registered execute bundle
    logic    access;     // Load or store held in ex_q

    // Pipeline register between execute and memory
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_q <= '0;
        end
        else
        begin
            ex_q <= ex_in;
        end
    end

    assign access = ex_q.mem_read | ex_q.mem_write;

    // RAM side, all straight from the register
    assign ram_addr  = ex_q.alu_result[RAM_AW+1:2];   // Word index, byte offset dropped
    assign ram_wdata = ex_q.store_data;
    assign ram_we    = ex_q.mem_write;                // RAM writes on the next edge

    // One pulse per access, lined up with the write-back result
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_done <= 1'b0;
        end
        else
        begin
            mem_done <= access;
        end
    end

    // Bundle for write-back, which registers it beside the RAM read
    always_comb
    begin
        mem_wb            = '0;
        mem_wb.alu_result = ex_q.alu_result;   // Full address, aliasing is RAM side only
        mem_wb.link_pc    = ex_q.link_pc;
        mem_wb.ctrl       = ex_q.ctrl;         // Passed through unchanged
    end

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

// Word-wide synchronous data memory. One write port and one
// registered read port on the same address.
module data_ram (
    input  logic                       clk,
    input  logic [cpu_pkg::RAM_AW-1:0] addr,
    input  logic [cpu_pkg::DATA_W-1:0] wdata,
    input  logic                       we,
    output logic [cpu_pkg::DATA_W-1:0] rdata
);

    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [0:RAM_WORDS-1];   // Storage array, contents undefined at start

    // Write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    // Read port, updated on every edge
    // A write to the same word shows up one cycle later
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];   // Old data on same-address write
    end

endmodule

`default_nettype wire

/* write_back.sv */
`timescale 1ns/10ps
`default_nettype none

// Write-back stage. The bundle is registered on the same edge the RAM
// registers its read word, so both are valid together here.
module write_back (
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_pkg::mem_wb_t           mem_wb,
    input  logic [cpu_pkg::DATA_W-1:0] ram_rdata,
    output cpu_pkg::wb_out_t           wb_out
);

    import cpu_pkg::*;

    mem_wb_t           wb_q;       // Registered memory bundle
    logic [DATA_W-1:0] reg_data;   // Selected register write value

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_q <= '0;   // Clears reg_write and pc_src with the rest
        end
        else
        begin
            wb_q <= mem_wb;
        end
    end

    // Link address wins, then the loaded word, then the ALU result
    always_comb
    begin
        if (wb_q.ctrl.reg_data_src)
        begin
            reg_data = wb_q.link_pc;
        end
        else if (wb_q.ctrl.mem_to_reg)
        begin
            reg_data = ram_rdata;
        end
        else
        begin
            reg_data = wb_q.alu_result;
        end
    end

    always_comb
    begin
        wb_out.reg_write = wb_q.ctrl.reg_write;
        wb_out.reg_dest  = wb_q.ctrl.reg_dest;
        wb_out.reg_data  = reg_data;
        wb_out.pc_src    = wb_q.ctrl.pc_src;
        wb_out.pc_target = wb_q.alu_result;   // Branch target computed in execute
    end

endmodule

`default_nettype wire

/* mem_wb_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

// Memory access and write-back end of the pipeline. A bundle sampled
// on one edge comes out as a result after the next edge.
module mem_wb_subsys (
    input  logic             clk,
    input  logic             rst,
    input  cpu_pkg::ex_mem_t ex_in,
    output logic             mem_done,
    output cpu_pkg::wb_out_t wb_out
);

    import cpu_pkg::*;

    logic [RAM_AW-1:0] ram_addr;    // Word index from the memory stage
    logic [DATA_W-1:0] ram_wdata;   // Store data
    logic              ram_we;      // Store strobe
    logic [DATA_W-1:0] ram_rdata;   // Registered read word
    mem_wb_t           mem_wb;      // Control and ALU data for write-back

    mem_stage mem_stage_0 (
        .clk       (clk),
        .rst       (rst),
        .ex_in     (ex_in),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .mem_wb    (mem_wb),
        .mem_done  (mem_done)
    );

    // Data memory, no reset
    data_ram data_ram_0 (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    write_back write_back_0 (
        .clk       (clk),
        .rst       (rst),
        .mem_wb    (mem_wb),
        .ram_rdata (ram_rdata),
        .wb_out    (wb_out)
    );

endmodule

`default_nettype wire

/* tb_mem_wb.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_wb;

    import cpu_pkg::*;

    localparam int CLK_HALF   = 20;    // 40 ns clock period
    localparam int RESET_TMO  = 20;    // Cycles allowed for reset release
    localparam int DRAIN_TMO  = 20;    // Cycles allowed for the queue to drain
    localparam int RAND_COUNT = 400;   // Random instructions in the long mix
    localparam int RAND_WORDS = 16;    // Words used by the random mix

    // One expected result, checked at the negedge of its due cycle
    typedef struct packed {
        wb_out_t     wb;
        logic        done;
        logic [31:0] due;
    } exp_t;

    logic        clk;
    logic        rst;
    ex_mem_t     ex_in;
    logic        mem_done;
    wb_out_t     wb_out;

    logic [DATA_W-1:0] shadow [0:RAM_WORDS-1];   // Reference copy of the data RAM
    exp_t              exp_q [$];                 // Results still in flight
    logic [31:0]       cycle = 0;                 // Rising edges seen so far
    integer            seed;

    mem_wb_subsys dut0 (
        .clk      (clk),
        .rst      (rst),
        .ex_in    (ex_in),
        .mem_done (mem_done),
        .wb_out   (wb_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_out_t got, input wb_out_t exp);
        if (got !== exp)
        begin
            $display("ERR wb_out got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR mem_done got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    // Expected result of one instruction from the register write select
    function automatic wb_out_t expect_wb(input ex_mem_t b);
        wb_out_t r;
        r.reg_write = b.ctrl.reg_write;
        r.reg_dest  = b.ctrl.reg_dest;
        r.pc_src    = b.ctrl.pc_src;
        r.pc_target = b.alu_result;
        if (b.ctrl.reg_data_src)
        begin
            r.reg_data = b.link_pc;
        end
        else if (b.ctrl.mem_to_reg)
        begin
            r.reg_data = shadow[b.alu_result[RAM_AW+1:2]];   // Word before this store
        end
        else
        begin
            r.reg_data = b.alu_result;
        end
        return r;
    endfunction

    function automatic ex_mem_t make_store(input logic [DATA_W-1:0] addr,
                                           input logic [DATA_W-1:0] data);
        ex_mem_t b;
        b            = '0;
        b.alu_result = addr;
        b.store_data = data;
        b.mem_write  = 1'b1;
        return b;
    endfunction

    function automatic ex_mem_t make_load(input logic [DATA_W-1:0] addr,
                                          input logic [REG_AW-1:0] rd);
        ex_mem_t b;
        b                 = '0;
        b.alu_result      = addr;
        b.mem_read        = 1'b1;
        b.ctrl.mem_to_reg = 1'b1;
        b.ctrl.reg_write  = 1'b1;
        b.ctrl.reg_dest   = rd;
        return b;
    endfunction

    function automatic ex_mem_t make_alu(input logic [DATA_W-1:0] result,
                                         input logic [REG_AW-1:0] rd);
        ex_mem_t b;
        b                = '0;
        b.alu_result     = result;
        b.ctrl.reg_write = 1'b1;
        b.ctrl.reg_dest  = rd;
        return b;
    endfunction

    // Drive one instruction and queue what must come out two edges later
    task automatic send(input ex_mem_t b);
        exp_t e;
        @(posedge clk);
        ex_in <= b;
        e.wb   = expect_wb(b);
        e.done = b.mem_read | b.mem_write;
        e.due  = cycle + 3;                       // Sampled next edge, result after the one after
        exp_q.push_back(e);
        if (b.mem_write)
        begin
            shadow[b.alu_result[RAM_AW+1:2]] = b.store_data;
        end
    endtask

    task automatic send_idle();
        send('0);
    endtask

    // At most one result is due per cycle
    task automatic check_due();
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due <= cycle)
        begin
            e = exp_q.pop_front();
            if (e.due != cycle)
            begin
                $display("An expected result was skipped at cycle %0d", cycle);
                abort_run();
            end
            else
            begin
                check_done(mem_done, e.done);
                check_wb(wb_out, e.wb);
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_due();
        end
    end

    task automatic wait_reset_release();
        int t;
        t = 0;
        while (rst === 1'b1 && t < RESET_TMO)
        begin
            @(posedge clk);
            t = t + 1;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset was not released in time");
            abort_run();
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < DRAIN_TMO)
        begin
            @(posedge clk);
            t = t + 1;
        end
        if (exp_q.size() != 0)
        begin
            $display("Results still pending after the drain timeout");
            abort_run();
        end
    endtask

    task automatic test_idle_after_reset();
        repeat (2)
        begin
            @(negedge clk);
            check_done(mem_done, 1'b0);
            check_wb(wb_out, '0);       // Idle input keeps the whole result at zero
        end
    endtask

    task automatic test_store_load();
        send(make_store(32'h0000_0080, 32'hDEAD_BEEF));
        send_idle();
        send(make_load(32'h0000_0080, 5'd3));
        send(make_store(32'h0000_0104, 32'h1234_5678));
        send(make_load(32'h0000_0104, 5'd7));    // Back to back with the store
        send(make_store(32'h0000_0108, 32'h0BAD_F00D));
        send(make_store(32'h0000_0108, 32'hCAFE_0001));
        send(make_load(32'h0000_0108, 5'd31));   // Sees the second store
        send_idle();
    endtask

    task automatic test_alu_pass();
        send(make_alu(32'h7777_1234, 5'd9));
        send(make_alu(32'hFFFF_FFFC, 5'd1));
        send_idle();
    endtask

    task automatic test_link_branch();
        ex_mem_t b;
        b                   = make_alu(32'h0000_2000, 5'd31);
        b.link_pc           = 32'h0000_1004;
        b.ctrl.reg_data_src = 1'b1;
        send(b);
        b                = '0;
        b.alu_result     = 32'h0000_3F00;
        b.ctrl.pc_src    = 1'b1;
        send(b);
        send_idle();
    endtask

    task automatic test_alias();
        send(make_store(32'h0000_0040, 32'hA5A5_5A5A));
        send(make_load(32'h1234_0040, 5'd12));   // Same word with other high bits
        send(make_store(32'h0000_0444, 32'h0F0F_F0F0));
        send(make_load(32'h0000_0044, 5'd13));   // Bit 10 only
        send_idle();
    endtask

    task automatic test_random_mix();
        ex_mem_t         b;
        int              kind;
        int              word;
        logic [DATA_W-1:0] addr;
        for (word = 0; word < RAND_WORDS; word++)
        begin
            send(make_store(word << 2, $random(seed)));
        end
        for (int i = 0; i < RAND_COUNT; i++)
        begin
            kind = $unsigned($random(seed)) % 3;
            word = $unsigned($random(seed)) % RAND_WORDS;
            addr = ($random(seed) & 32'hFFFF_FC00) | (word << 2);
            case (kind)
                0:
                begin
                    b = make_store(addr, $random(seed));
                end
                1:
                begin
                    b = make_load(addr, REG_AW'($random(seed)));
                end
                default:
                begin
                    b                   = make_alu($random(seed), REG_AW'($random(seed)));
                    b.link_pc           = $random(seed);
                    b.ctrl.reg_data_src = 1'($random(seed));
                    b.ctrl.reg_write    = 1'($random(seed));
                end
            endcase
            b.ctrl.pc_src = 1'($random(seed));
            send(b);
        end
        send_idle();
    endtask

    initial
    begin : main_flow
        ex_in     = '0;
        seed      = 64;
        wait_reset_release();
        test_idle_after_reset();
        test_store_load();
        test_alu_pass();
        test_link_branch();
        test_alias();
        test_random_mix();
        wait_drain();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
cpu_pkg.sv
mem_stage.sv
data_ram.sv
write_back.sv
mem_wb_subsys.sv
tb_mem_wb.sv
